/* design/display_pkg.sv */
// shared widths, the RGB555 colour word and the DVI control symbols
// modules import this in their body; port lists use scoped names

package display_pkg;

    localparam int cordw     = 16;  // screen coordinate width
    localparam int canv_bpp  = 4;   // canvas bits per pixel, 16 palette entries
    localparam int bpc       = 5;   // palette bits per channel
    localparam int bpc_board = 8;   // bits per channel on the DVI link

    // rgb555 fields, red in the top bits as the host writes them
    typedef struct packed {
        logic [bpc-1:0] r;
        logic [bpc-1:0] g;
        logic [bpc-1:0] b;
    } rgb_t;

    // the same word seen raw or split into channels
    typedef union packed {
        logic [3*bpc-1:0] raw;  // palette write data, background value
        rgb_t             ch;   // per-channel view for widening
    } colr_t;

    // TMDS control period symbols, indexed by {c1, c0}
    // bit 0 is sent first on the wire
    localparam logic [3:0][9:0] ctrl_sym = {
        10'b1010101011,  // c = 11
        10'b0101010100,  // c = 10
        10'b0010101011,  // c = 01, hsync only on ch0
        10'b1101010100   // c = 00, idle blanking
    };

endpackage

/* design/display_timing.sv */
// raster timing generator: pixel and line counters plus sync, de and frame start
// all outputs are registered and line up with sx/sy on the same cycle

module display_timing #(
    parameter int H_RES  = 640,  // active pixels per line
    parameter int H_FP   = 16,   // horizontal front porch
    parameter int H_SYNC = 96,   // hsync width
    parameter int H_BP   = 48,   // horizontal back porch
    parameter int V_RES  = 480,  // active lines
    parameter int V_FP   = 10,   // vertical front porch
    parameter int V_SYNC = 2,    // vsync width in lines
    parameter int V_BP   = 33    // vertical back porch
) (
    input  logic                          clk_pix,
    input  logic                          rst_n,
    output logic [display_pkg::cordw-1:0] sx,  // pixel position in line
    output logic [display_pkg::cordw-1:0] sy,  // line position in frame
    output logic                          de,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          frame_start
);
    import display_pkg::*;

    localparam int H_TOTAL  = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL  = V_RES + V_FP + V_SYNC + V_BP;
    localparam int HS_START = H_RES + H_FP;       // first hsync pixel
    localparam int HS_END   = HS_START + H_SYNC;  // first pixel after hsync
    localparam int VS_START = V_RES + V_FP;
    localparam int VS_END   = VS_START + V_SYNC;

    logic [cordw-1:0] sx_nxt;
    logic [cordw-1:0] sy_nxt;

    // next raster position, wraps at end of line and end of frame
    always_comb begin
        sx_nxt = sx + 1'b1;
        sy_nxt = sy;
        if (sx == cordw'(H_TOTAL - 1)) begin
            sx_nxt = '0;
            sy_nxt = (sy == cordw'(V_TOTAL - 1)) ? '0 : sy + 1'b1;
        end
    end

    // flags come from the next position so they match the counters
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx          <= '0;
            sy          <= '0;
            de          <= 1'b0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            frame_start <= 1'b0;  // first frame after reset has no start pulse
        end else begin
            sx          <= sx_nxt;
            sy          <= sy_nxt;
            de          <= (sx_nxt < cordw'(H_RES)) && (sy_nxt < cordw'(V_RES));
            hsync       <= (sx_nxt >= cordw'(HS_START)) && (sx_nxt < cordw'(HS_END));
            vsync       <= (sy_nxt >= cordw'(VS_START)) && (sy_nxt < cordw'(VS_END));
            frame_start <= (sx_nxt == '0) && (sy_nxt == '0);
        end
    end

endmodule

/* design/canvas_window.sv */
// places the scaled canvas on screen and produces the framebuffer read address
// flags leave two cycles late so they meet the registered read data

module canvas_window #(
    parameter int CANV_WIDTH  = 160,  // canvas width in pixels
    parameter int CANV_HEIGHT = 120,  // canvas height in lines
    parameter int CANV_SCALE  = 4,    // integer zoom in both directions
    parameter int WIN_STARTX  = 0,    // window left edge on screen
    parameter int WIN_STARTY  = 0,    // window top edge on screen
    localparam int ADDRW = $clog2(CANV_WIDTH * CANV_HEIGHT)
) (
    input  logic                          clk_pix,
    input  logic                          rst_n,
    input  logic [display_pkg::cordw-1:0] sx,
    input  logic [display_pkg::cordw-1:0] sy,
    input  logic                          de,
    input  logic                          hsync,
    input  logic                          vsync,
    output logic [ADDRW-1:0]              rd_addr,  // row-major canvas address
    output logic                          in_win,
    output logic                          de_q,
    output logic                          hsync_q,
    output logic                          vsync_q
);
    import display_pkg::*;

    localparam int WIN_ENDX = WIN_STARTX + CANV_WIDTH * CANV_SCALE;   // exclusive
    localparam int WIN_ENDY = WIN_STARTY + CANV_HEIGHT * CANV_SCALE;  // exclusive

    logic             x_in, y_in;
    logic [ADDRW-1:0] cx;        // canvas column
    logic [ADDRW-1:0] row_base;  // canvas row times width, kept by addition
    logic [cordw-1:0] cx_sub, cy_sub;  // repeat counters within one canvas pixel
    logic             win_d, de_d, hs_d, vs_d;  // first delay stage

    assign x_in = (sx >= cordw'(WIN_STARTX)) && (sx < cordw'(WIN_ENDX));
    assign y_in = (sy >= cordw'(WIN_STARTY)) && (sy < cordw'(WIN_ENDY));

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            cx <= '0;
            cx_sub <= '0;
            row_base <= '0;
            cy_sub <= '0;
        end else begin
            if (!x_in) begin  // park at column 0 until the left edge
                cx     <= '0;
                cx_sub <= '0;
            end else if (cx_sub == cordw'(CANV_SCALE - 1)) begin
                cx     <= cx + 1'b1;
                cx_sub <= '0;
            end else begin
                cx_sub <= cx_sub + 1'b1;
            end

            if (!y_in) begin  // above or below the window
                row_base <= '0;
                cy_sub   <= '0;
            end else if (sx == cordw'(WIN_ENDX - 1)) begin  // last window pixel of line
                if (cy_sub == cordw'(CANV_SCALE - 1)) begin
                    row_base <= row_base + ADDRW'(CANV_WIDTH);
                    cy_sub   <= '0;
                end else begin
                    cy_sub <= cy_sub + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_pix) rd_addr <= row_base + cx;  // stage 1 framebuffer address

    // two-stage flag delay
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            {win_d, de_d, hs_d, vs_d}          <= '0;
            {in_win, de_q, hsync_q, vsync_q}   <= '0;
        end else begin
            win_d   <= de && x_in && y_in;
            de_d    <= de;
            hs_d    <= hsync;
            vs_d    <= vsync;
            in_win  <= win_d;
            de_q    <= de_d;
            hsync_q <= hs_d;
            vsync_q <= vs_d;
        end
    end

endmodule

/* design/canvas_buffer.sv */
// framebuffer of palette indices, host write port and one pipelined read port
// read data appears one cycle after rd_addr; infers a simple dual-port RAM

module canvas_buffer #(
    parameter int DEPTH = 19200  // canvas pixels, width times height
) (
    input  logic                             clk_pix,
    input  logic                             canv_we,    // host write strobe
    input  logic [$clog2(DEPTH)-1:0]         canv_addr,  // y * width + x
    input  logic [display_pkg::canv_bpp-1:0] canv_data,
    input  logic [$clog2(DEPTH)-1:0]         rd_addr,
    output logic [display_pkg::canv_bpp-1:0] rd_idx      // palette index
);
    import display_pkg::*;

    logic [canv_bpp-1:0] mem [DEPTH];

    // write port, takes effect on the strobe edge
    always_ff @(posedge clk_pix) begin
        if (canv_we) begin
            mem[canv_addr] <= canv_data;
        end
    end

    // read port
    // same-address collision returns the old index
    always_ff @(posedge clk_pix) begin
        rd_idx <= mem[rd_addr];
    end

endmodule

/* design/palette_lookup.sv */
// 16-entry RGB555 palette with background fill outside the canvas window
// output channels are widened to 8 bits and registered with de and syncs

module palette_lookup #(
    parameter display_pkg::colr_t BG_COLR = 15'h0886  // fill colour outside window
) (
    input  logic                              clk_pix,
    input  logic                              rst_n,
    input  logic                              pal_we,    // host palette write
    input  logic [display_pkg::canv_bpp-1:0]  pal_idx,
    input  display_pkg::colr_t                pal_colr,
    input  logic [display_pkg::canv_bpp-1:0]  rd_idx,    // from framebuffer
    input  logic                              in_win,
    input  logic                              de_in,
    input  logic                              hsync_in,
    input  logic                              vsync_in,
    output logic [display_pkg::bpc_board-1:0] red,
    output logic [display_pkg::bpc_board-1:0] green,
    output logic [display_pkg::bpc_board-1:0] blue,
    output logic                              de_out,
    output logic                              hsync_out,
    output logic                              vsync_out
);
    import display_pkg::*;

    colr_t pal_mem [2**canv_bpp];  // small enough for distributed RAM
    colr_t colr;

    // 5 to 8 bits, top bits repeated below so full scale stays full scale
    function automatic logic [bpc_board-1:0] widen(input logic [bpc-1:0] c);
        return {c, c[bpc-1:bpc-3]};
    endfunction

    always_ff @(posedge clk_pix) if (pal_we) pal_mem[pal_idx] <= pal_colr;

    assign colr = in_win ? pal_mem[rd_idx] : BG_COLR;  // async palette read

    always_ff @(posedge clk_pix) begin
        red   <= widen(colr.ch.r);
        green <= widen(colr.ch.g);
        blue  <= widen(colr.ch.b);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            {de_out, hsync_out, vsync_out} <= '0;
        end else begin
            de_out    <= de_in;
            hsync_out <= hsync_in;
            vsync_out <= vsync_in;
        end
    end

endmodule

/* design/tmds_encoder.sv */
// DVI TMDS encoder for one channel, 8-bit data or 2-bit control to a 10-bit symbol
// one cycle latency; running disparity is held during de and cleared in blanking

module tmds_encoder (
    input  logic       clk_pix,
    input  logic       rst_n,
    input  logic [7:0] din,   // pixel byte
    input  logic [1:0] ctrl,  // control value for blanking
    input  logic       de,
    output logic [9:0] tout   // bit 0 sent first
);
    import display_pkg::*;

    logic [3:0]        n1_d;      // ones in din
    logic [3:0]        n1_q;      // ones in q_m[7:0]
    logic              use_xnor;
    logic [8:0]        q_m;       // transition-minimised word
    logic signed [5:0] bal;       // ones minus zeros of q_m[7:0]
    logic signed [5:0] cnt;       // running disparity
    logic signed [5:0] cnt_nxt;
    logic [9:0]        sym_nxt;

    // stage one, chain of XOR or XNOR
    always_comb begin
        n1_d = '0;
        for (int i = 0; i < 8; i++) begin
            n1_d = n1_d + {3'b000, din[i]};
        end
        use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !din[0]);
        q_m[0] = din[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = q_m[i-1] ^ din[i] ^ use_xnor;  // xor with 1 gives xnor
        end
        q_m[8] = !use_xnor;  // flags the xor form for the decoder
    end

    // stage two, dc balance against the running disparity
    always_comb begin
        n1_q = '0;
        for (int i = 0; i < 8; i++) begin
            n1_q = n1_q + {3'b000, q_m[i]};
        end
        bal = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;  // 2*n1 - 8

        if (cnt == 6'sd0 || bal == 6'sd0) begin  // no bias either way
            sym_nxt = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            cnt_nxt = q_m[8] ? cnt + bal : cnt - bal;
        end else if ((cnt > 6'sd0 && bal > 6'sd0) || (cnt < 6'sd0 && bal < 6'sd0)) begin
            sym_nxt = {1'b1, q_m[8], ~q_m[7:0]};  // invert to pull back toward zero
            cnt_nxt = cnt + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
        end else begin
            sym_nxt = {1'b0, q_m[8], q_m[7:0]};
            cnt_nxt = cnt - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            tout <= ctrl_sym[0];
            cnt  <= '0;
        end else if (de) begin
            tout <= sym_nxt;
            cnt  <= cnt_nxt;
        end else begin
            tout <= ctrl_sym[ctrl];  // blanking, disparity restarts
            cnt  <= '0;
        end
    end

endmodule

/* design/display_top.sv */
// indexed-colour display pipeline from raster timing to three TMDS symbol streams
// host loads canvas and palette through write strobes; symbols lag the counters by 4

module display_top #(
    parameter int H_RES       = 640,
    parameter int H_FP        = 16,
    parameter int H_SYNC      = 96,
    parameter int H_BP        = 48,
    parameter int V_RES       = 480,
    parameter int V_FP        = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BP        = 33,
    parameter int CANV_WIDTH  = 160,  // canvas fills 640x480 at scale 4
    parameter int CANV_HEIGHT = 120,
    parameter int CANV_SCALE  = 4,
    parameter int WIN_STARTX  = 0,
    parameter int WIN_STARTY  = 0,
    parameter display_pkg::colr_t BG_COLR = 15'h0886,
    localparam int CANV_DEPTH = CANV_WIDTH * CANV_HEIGHT,
    localparam int ADDRW      = $clog2(CANV_DEPTH)
) (
    input  logic                             clk_pix,
    input  logic                             rst_n,
    input  logic                             canv_we,
    input  logic [ADDRW-1:0]                 canv_addr,
    input  logic [display_pkg::canv_bpp-1:0] canv_data,
    input  logic                             pal_we,
    input  logic [display_pkg::canv_bpp-1:0] pal_idx,
    input  display_pkg::colr_t               pal_colr,
    output logic                             frame_start,  // not delayed
    output logic [9:0]                       tmds_ch0,     // blue plus syncs
    output logic [9:0]                       tmds_ch1,     // green
    output logic [9:0]                       tmds_ch2      // red
);
    import display_pkg::*;

    logic [cordw-1:0]     sx, sy;
    logic                 de, hsync, vsync;               // stage 0
    logic [ADDRW-1:0]     rd_addr;                        // stage 1
    logic                 win_q, de_q, hs_q, vs_q;        // stage 2
    logic [canv_bpp-1:0]  rd_idx;
    logic [bpc_board-1:0] red, green, blue;               // stage 3
    logic                 de_c, hs_c, vs_c;

    display_timing #(.H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)) timing_inst (
        .clk_pix, .rst_n, .sx, .sy, .de, .hsync, .vsync, .frame_start);

    canvas_window #(.CANV_WIDTH(CANV_WIDTH), .CANV_HEIGHT(CANV_HEIGHT),
        .CANV_SCALE(CANV_SCALE), .WIN_STARTX(WIN_STARTX), .WIN_STARTY(WIN_STARTY)) win_inst (
        .clk_pix, .rst_n, .sx, .sy, .de, .hsync, .vsync, .rd_addr,
        .in_win(win_q), .de_q, .hsync_q(hs_q), .vsync_q(vs_q));

    canvas_buffer #(.DEPTH(CANV_DEPTH)) canv_inst (
        .clk_pix, .canv_we, .canv_addr, .canv_data, .rd_addr, .rd_idx);

    palette_lookup #(.BG_COLR(BG_COLR)) pal_inst (
        .clk_pix, .rst_n, .pal_we, .pal_idx, .pal_colr, .rd_idx, .in_win(win_q),
        .de_in(de_q), .hsync_in(hs_q), .vsync_in(vs_q), .red, .green, .blue,
        .de_out(de_c), .hsync_out(hs_c), .vsync_out(vs_c));

    // syncs ride on ch0 only, as DVI requires
    tmds_encoder tmds_ch0_inst (.clk_pix, .rst_n, .din(blue), .ctrl({vs_c, hs_c}),
        .de(de_c), .tout(tmds_ch0));
    tmds_encoder tmds_ch1_inst (.clk_pix, .rst_n, .din(green), .ctrl(2'b00),
        .de(de_c), .tout(tmds_ch1));
    tmds_encoder tmds_ch2_inst (.clk_pix, .rst_n, .din(red), .ctrl(2'b00),
        .de(de_c), .tout(tmds_ch2));

endmodule

/* tests/display_checks.svh */
// compare tasks and the TMDS decode helper for the display testbench
// included inside display_tb after the error counter is declared

task automatic check_sym(input string name, input logic [9:0] exp, input logic [9:0] got);
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s: expected %h actual %h", name, exp, got);
    end
endtask

task automatic check_colr(input string name, input display_pkg::colr_t exp,
                          input display_pkg::colr_t got);
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s: expected %h actual %h", name, exp.raw, got.raw);
    end
endtask

task automatic check_count(input string name, input int exp, input int got);
    if (got != exp) begin
        errors++;
        $display("Mismatch %s: expected %0d actual %0d", name, exp, got);
    end
endtask

// undo the bit 9 inversion, then the xor or xnor chain flagged by bit 8
function automatic logic [7:0] tmds_decode(input logic [9:0] sym);
    logic [7:0] q;
    logic [7:0] d;
    q = sym[9] ? ~sym[7:0] : sym[7:0];
    d[0] = q[0];
    for (int i = 1; i < 8; i++) begin
        d[i] = sym[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
    end
    return d;
endfunction

/* tests/display_tb.sv */
// directed testbench for display_top in a tiny 16x8 video mode
// captures whole frames of TMDS symbols and checks them against a canvas and palette model

module display_tb;
    import display_pkg::*;

    localparam int H_TOT = 24;             // 16 + 2 + 3 + 3
    localparam int V_TOT = 12;             // 8 + 1 + 2 + 1
    localparam int FRAME = H_TOT * V_TOT;
    localparam colr_t BG = 15'h0886;

    logic        clk_pix = 1'b0;
    logic        rst_n;
    logic        canv_we, pal_we;
    logic [2:0]  canv_addr;
    logic [3:0]  canv_data, pal_idx;
    colr_t       pal_colr;
    logic        frame_start;
    logic [9:0]  tmds_ch0, tmds_ch1, tmds_ch2;
    int          errors = 0;
    int          tests = 0;
    colr_t       pal_model [16];
    logic [3:0]  canv_model [8];
    logic [9:0]  cap0 [FRAME], cap1 [FRAME], cap2 [FRAME];  // symbols by screen position
    colr_t       prev_colr [FRAME];

    `include "display_checks.svh"

    always #5 clk_pix = ~clk_pix;

    display_top #(.H_RES(16), .H_FP(2), .H_SYNC(3), .H_BP(3), .V_RES(8), .V_FP(1),
        .V_SYNC(2), .V_BP(1), .CANV_WIDTH(4), .CANV_HEIGHT(2), .CANV_SCALE(2),
        .WIN_STARTX(4), .WIN_STARTY(2), .BG_COLR(BG)) UUT (
        .clk_pix, .rst_n, .canv_we, .canv_addr, .canv_data, .pal_we, .pal_idx,
        .pal_colr, .frame_start, .tmds_ch0, .tmds_ch1, .tmds_ch2);

    function automatic logic [7:0] expand(input logic [4:0] c);
        return {c, c[4:2]};  // top bits repeated below
    endfunction

    function automatic bit in_window(input int x, input int y);
        return x >= 4 && x < 12 && y >= 2 && y < 6;
    endfunction

    function automatic colr_t expected_colr(input int x, input int y);
        if (!in_window(x, y)) return BG;
        return pal_model[canv_model[((y - 2) / 2) * 4 + (x - 4) / 2]];
    endfunction

    function automatic colr_t decoded_colr(input int p);
        colr_t c;
        logic [7:0] r, g, b;
        r = tmds_decode(cap2[p]);
        g = tmds_decode(cap1[p]);
        b = tmds_decode(cap0[p]);
        c.ch.r = r[7:3];
        c.ch.g = g[7:3];
        c.ch.b = b[7:3];
        return c;
    endfunction

    // DVI encoding rule, written from the spec
    function automatic logic [9:0] tmds_model(input logic [7:0] d, input int disp);
        logic [8:0] qm;
        int ones;
        bit use_xnor;
        ones = $countones(d);
        use_xnor = ones > 4 || (ones == 4 && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = use_xnor ? ~(qm[i-1] ^ d[i]) : qm[i-1] ^ d[i];
        end
        qm[8] = !use_xnor;
        ones = $countones(qm[7:0]);
        if (disp == 0 || ones == 4) begin
            return {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
        end
        if ((disp > 0 && ones > 4) || (disp < 0 && ones < 4)) begin
            return {1'b1, qm[8], ~qm[7:0]};
        end
        return {1'b0, qm[8], qm[7:0]};
    endfunction

    task automatic check_pixel(input int x, input int y, input string tname);
        int p;
        colr_t got;
        p = y * H_TOT + x;
        got = decoded_colr(p);
        check_colr($sformatf("%s (%0d,%0d)", tname, x, y), expected_colr(x, y), got);
        if (tmds_decode(cap2[p]) != expand(got.ch.r) ||
            tmds_decode(cap1[p]) != expand(got.ch.g) ||
            tmds_decode(cap0[p]) != expand(got.ch.b)) begin
            errors++;
            $display("%s: low channel bits at (%0d,%0d) are not a widened 5-bit value",
                     tname, x, y);
        end
    endtask

    task automatic wait_frame(output bit ok);
        ok = 0;
        for (int n = 0; n < FRAME + 8; n++) begin
            @(negedge clk_pix);
            if (frame_start) begin
                ok = 1;
                break;
            end
        end
        if (!ok) begin
            errors++;
            $display("Timeout: frame_start did not arrive within one frame period");
        end
    endtask

    task automatic capture_frame(output bit ok);
        wait_frame(ok);
        if (!ok) return;
        repeat (4) @(negedge clk_pix);  // pipeline latency
        for (int p = 0; p < FRAME; p++) begin
            cap0[p] = tmds_ch0;
            cap1[p] = tmds_ch1;
            cap2[p] = tmds_ch2;
            @(negedge clk_pix);
        end
    endtask

    task automatic write_palette(input int idx, input colr_t c);
        @(negedge clk_pix);
        pal_we = 1'b1;
        pal_idx = idx[3:0];
        pal_colr = c;
        @(negedge clk_pix);
        pal_we = 1'b0;
        pal_model[idx] = c;
    endtask

    task automatic write_canvas(input int addr, input logic [3:0] idx);
        @(negedge clk_pix);
        canv_we = 1'b1;
        canv_addr = addr[2:0];
        canv_data = idx;
        @(negedge clk_pix);
        canv_we = 1'b0;
        canv_model[addr] = idx;
    endtask

    task automatic report_test(input string tname, input int errs_before);
        tests++;
        $display("test %s finished with %0d errors", tname, errors - errs_before);
    endtask

    task automatic reset_test();
        int e0;
        bit ok;
        e0 = errors;
        rst_n = 1'b0;
        for (int i = 0; i <= 4; i++) begin  // 4 reset cycles, then the first free one
            @(negedge clk_pix);
            if (i == 3) rst_n = 1'b1;
            check_sym("reset ch0", ctrl_sym[0], tmds_ch0);
            check_sym("reset ch1", ctrl_sym[0], tmds_ch1);
            check_sym("reset ch2", ctrl_sym[0], tmds_ch2);
            check_count("reset frame_start", 0, int'(frame_start));
        end
        wait_frame(ok);
        report_test("reset", e0);
    endtask

    task automatic sync_test();
        int e0, n, hs, vs, p;
        bit ok;
        logic [9:0] exp0;
        e0 = errors;
        wait_frame(ok);
        for (n = 1; n < 2 * FRAME; n++) begin
            @(negedge clk_pix);
            if (frame_start) break;
        end
        if (n == 2 * FRAME) begin
            errors++;
            $display("Timeout: frame_start did not return within two frame periods");
        end else begin
            check_count("frame period", FRAME, n);
        end
        capture_frame(ok);
        vs = 0;
        for (int y = 0; y < V_TOT; y++) begin
            hs = 0;
            for (int x = 0; x < H_TOT; x++) begin
                if (x < 16 && y < 8) continue;
                p = y * H_TOT + x;
                exp0 = ctrl_sym[{y >= 9 && y < 11, x >= 18 && x < 21}];
                check_sym($sformatf("sync ch0 (%0d,%0d)", x, y), exp0, cap0[p]);
                check_sym($sformatf("sync ch1 (%0d,%0d)", x, y), ctrl_sym[0], cap1[p]);
                check_sym($sformatf("sync ch2 (%0d,%0d)", x, y), ctrl_sym[0], cap2[p]);
                if (cap0[p] inside {ctrl_sym[1], ctrl_sym[3]}) hs++;
            end
            check_count($sformatf("hsync symbols line %0d", y), 3, hs);
            if (cap0[y * H_TOT] == ctrl_sym[2]) vs++;  // vsync without hsync at line start
        end
        check_count("vsync lines", 2, vs);
        report_test("sync", e0);
    endtask

    task automatic background_test();
        int e0;
        bit ok;
        e0 = errors;
        capture_frame(ok);
        for (int y = 0; y < 8; y++)
            for (int x = 0; x < 16; x++)
                if (!in_window(x, y)) check_pixel(x, y, "background");
        report_test("background", e0);
    endtask

    task automatic canvas_test();
        int e0;
        bit ok;
        colr_t c;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            c.raw = 15'($urandom());
            write_palette(i, c);
        end
        for (int i = 0; i < 8; i++) write_canvas(i, 4'($urandom()));
        capture_frame(ok);
        for (int y = 0; y < 8; y++)
            for (int x = 0; x < 16; x++) begin
                if (in_window(x, y)) check_pixel(x, y, "canvas");
                prev_colr[y * H_TOT + x] = expected_colr(x, y);  // model view of this frame
            end
        report_test("canvas", e0);
    endtask

    // exact symbols and wire balance, per line, from the last capture
    task automatic dc_balance_test();
        int e0, d0, d1, d2, p;
        e0 = errors;
        for (int y = 0; y < 8; y++) begin
            d0 = 0;
            d1 = 0;
            d2 = 0;
            for (int x = 0; x < 16; x++) begin
                p = y * H_TOT + x;
                check_sym($sformatf("dc ch0 (%0d,%0d)", x, y),
                          tmds_model(tmds_decode(cap0[p]), d0), cap0[p]);
                check_sym($sformatf("dc ch1 (%0d,%0d)", x, y),
                          tmds_model(tmds_decode(cap1[p]), d1), cap1[p]);
                check_sym($sformatf("dc ch2 (%0d,%0d)", x, y),
                          tmds_model(tmds_decode(cap2[p]), d2), cap2[p]);
                d0 += 2 * $countones(cap0[p]) - 10;
                d1 += 2 * $countones(cap1[p]) - 10;
                d2 += 2 * $countones(cap2[p]) - 10;
                if (d0 > 16 || d0 < -16 || d1 > 16 || d1 < -16 || d2 > 16 || d2 < -16) begin
                    errors++;
                    $display("running disparity out of bounds at (%0d,%0d)", x, y);
                end
            end
        end
        report_test("dc_balance", e0);
    endtask

    task automatic update_test();
        int e0, e, j, want, got;
        bit ok;
        colr_t c;
        e0 = errors;
        e = $urandom() % 16;
        j = $urandom() % 8;
        c.raw = pal_model[e].raw ^ 15'(($urandom() % 32767) + 1);  // always a new colour
        write_palette(e, c);
        write_canvas(j, canv_model[j] ^ 4'(($urandom() % 15) + 1));
        capture_frame(ok);
        want = 0;
        got = 0;
        for (int y = 0; y < 8; y++)
            for (int x = 0; x < 16; x++) begin
                check_pixel(x, y, "update");
                if (expected_colr(x, y) != prev_colr[y * H_TOT + x]) want++;
                if (decoded_colr(y * H_TOT + x) != prev_colr[y * H_TOT + x]) got++;
            end
        check_count("update changed positions", want, got);
        report_test("update", e0);
    endtask

    initial begin
        void'($urandom(68414));
        rst_n = 1'b0;
        canv_we = 1'b0;
        canv_addr = '0;
        canv_data = '0;
        pal_we = 1'b0;
        pal_idx = '0;
        pal_colr = '0;
        reset_test();
        sync_test();
        background_test();
        canvas_test();
        dc_balance_test();
        update_test();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+tests
design/display_pkg.sv
design/display_timing.sv
design/canvas_window.sv
design/canvas_buffer.sv
design/palette_lookup.sv
design/tmds_encoder.sv
design/display_top.sv
tests/display_tb.sv

/* run_sim.sh */
#!/bin/bash
# build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module display_tb -f files.f \
    -o display_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/display_sim > sim.log 2>&1 || { cat sim.log; echo "run failed"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || { echo "no result in log"; exit 1; }
exit 0
